// File: source/mips_pkg.sv
package mips_pkg;

    // ------------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [1:0]  size_t;

    // ALU operations selected in decode
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_t;

    // Syscall drain FSM in decode
    typedef enum logic [1:0] {
        st_run,
        st_drain,
        st_sys
    } dec_state_t;

    // ------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sw      = 6'h2b;

    // Function codes of the special opcode
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;

    // Store sizes in bytes, four bytes encoded as 0
    localparam size_t size_word = 2'd0;
    localparam size_t size_byte = 2'd1;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

// File: source/pipe_if.sv
`timescale 1ns/10ps

// Fetch to decode, with stall and redirect going back
interface if_id_if;
    import mips_pkg::*;

    instr_t instr;
    word_t  pc_plus4;
    logic   valid;
    logic   stall;
    logic   redirect;
    word_t  target;

    modport fetch  (output instr, pc_plus4, valid, input stall, redirect, target);
    modport decode (input instr, pc_plus4, valid, output stall, redirect, target);
endinterface

// Decode to execute
interface id_ex_if;
    import mips_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    shamt_t    shamt;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    size_t     store_size;
    word_t     store_data;

    modport decode (output valid, alu_op, operand_a, operand_b, shamt, dest, reg_write,
                    mem_read, mem_write, store_size, store_data);
    modport execute (input valid, alu_op, operand_a, operand_b, shamt, dest, reg_write,
                     mem_read, mem_write, store_size, store_data);
endinterface

// Execute to memory, plus a read-only view for the decode interlock
interface ex_mem_if;
    import mips_pkg::*;

    logic      valid;
    word_t     result;
    reg_addr_t dest;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    size_t     store_size;
    word_t     store_data;

    modport execute (output valid, result, dest, reg_write, mem_read, mem_write,
                     store_size, store_data);
    modport memory  (input valid, result, dest, reg_write, mem_read, mem_write,
                     store_size, store_data);
    modport monitor (input valid, dest, reg_write);
endinterface

// Memory to the register file write port
interface mem_wb_if;
    import mips_pkg::*;

    logic      reg_write;
    reg_addr_t dest;
    word_t     data;

    modport memory  (output reg_write, dest, data);
    modport regfile (input reg_write, dest, data);
endinterface

// File: source/mips_fetch.sv
`timescale 1ns/10ps

module mips_fetch (
    input  logic            CLK,
    input  logic            RESET,
    output mips_pkg::word_t instr_addr,
    input  mips_pkg::instr_t instr,
    if_id_if.fetch          fd
);
    import mips_pkg::*;

    word_t pc;
    word_t pc_plus4;

    assign pc_plus4   = pc + 32'd4;
    assign instr_addr = pc;

    // ------------------------------------------------------------------
    // Program counter and fetch/decode valid
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pc       <= reset_pc;
            fd.valid <= 1'b0;
        end else if (!fd.stall) begin
            // Delay slot already fetched this cycle, so redirect only moves the PC
            if (fd.redirect) begin
                pc <= fd.target;
            end else begin
                pc <= pc_plus4;
            end
            fd.valid <= 1'b1;
        end
    end

    // Fetched word held while decode stalls
    always_ff @(posedge CLK) begin
        if (!fd.stall) begin
            fd.instr    <= instr;
            fd.pc_plus4 <= pc_plus4;
        end
    end

endmodule

// File: source/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile (
    input  logic               CLK,
    input  logic               RESET,
    mem_wb_if.regfile          wb,
    input  mips_pkg::reg_addr_t read_a,
    input  mips_pkg::reg_addr_t read_b,
    output mips_pkg::word_t    data_a,
    output mips_pkg::word_t    data_b
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through so the write-back value reaches decode in the same cycle
    assign data_a = (read_a == '0) ? '0 :
                    (wb.reg_write && wb.dest == read_a) ? wb.data :
                    regs[read_a];

    assign data_b = (read_b == '0) ? '0 :
                    (wb.reg_write && wb.dest == read_b) ? wb.data :
                    regs[read_b];

endmodule

// File: source/mips_decode.sv
`timescale 1ns/10ps

module mips_decode (
    input  logic      CLK,
    input  logic      RESET,
    if_id_if.decode   fd,
    id_ex_if.decode   de,
    ex_mem_if.monitor em,
    mem_wb_if.regfile wb,
    output logic      sys
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm;
    word_t      data_a;
    word_t      data_b;
    alu_op_t    alu_op;
    reg_addr_t  dest;
    size_t      size;
    logic       use_imm, use_rs, use_rt;
    logic       reg_write, mem_read, mem_write;
    logic       is_beq, is_bne, is_jump, is_sys;
    logic       busy_a, busy_b, hazard, issue, taken;
    dec_state_t state;

    assign opcode = fd.instr[31:26];
    assign rs     = fd.instr[25:21];
    assign rt     = fd.instr[20:16];
    assign rd     = fd.instr[15:11];
    assign funct  = fd.instr[5:0];
    assign imm    = {{16{fd.instr[15]}}, fd.instr[15:0]};

    mips_regfile u_regfile (
        .CLK    (CLK),
        .RESET  (RESET),
        .wb     (wb),
        .read_a (rs),
        .read_b (rt),
        .data_a (data_a),
        .data_b (data_b)
    );

    // ------------------------------------------------------------------
    // Instruction crack
    // ------------------------------------------------------------------
    always_comb begin
        alu_op    = alu_add;
        dest      = rt;
        size      = size_word;
        use_imm   = 1'b1;
        use_rs    = 1'b0;
        use_rt    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_jump   = 1'b0;
        is_sys    = 1'b0;
        case (opcode)
            op_special: begin
                dest      = rd;
                use_imm   = 1'b0;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        alu_op = alu_sll;
                        use_rs = 1'b0;
                    end
                    fn_syscall: begin
                        is_sys    = 1'b1;
                        use_rs    = 1'b0;
                        use_rt    = 1'b0;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu: begin
                use_rs    = 1'b1;
                reg_write = 1'b1;
            end
            op_lui: begin
                alu_op    = alu_lui;
                reg_write = 1'b1;
            end
            op_lw: begin
                use_rs    = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            op_sw, op_sb: begin
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                mem_write = 1'b1;
                size      = (opcode == op_sb) ? size_byte : size_word;
            end
            op_beq, op_bne: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = (opcode == op_beq);
                is_bne = (opcode == op_bne);
            end
            op_j:    is_jump = 1'b1;
            default: use_imm = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // Interlock against execute and memory, no forwarding
    // ------------------------------------------------------------------
    assign busy_a = use_rs && (rs != '0) &&
                    ((de.valid && de.reg_write && de.dest == rs) ||
                     (em.valid && em.reg_write && em.dest == rs));
    assign busy_b = use_rt && (rt != '0) &&
                    ((de.valid && de.reg_write && de.dest == rt) ||
                     (em.valid && em.reg_write && em.dest == rt));
    assign hazard = fd.valid && (busy_a || busy_b);

    // Syscall never issues as a real instruction
    assign issue    = fd.valid && (state == st_run) && !hazard && !is_sys;
    assign fd.stall = hazard || (state == st_drain) ||
                      ((state == st_run) && fd.valid && is_sys);

    // Branches resolve here
    assign taken       = is_jump || (is_beq && data_a == data_b) ||
                         (is_bne && data_a != data_b);
    assign fd.redirect = issue && taken;
    assign fd.target   = is_jump ? {fd.pc_plus4[31:28], fd.instr[25:0], 2'b00} :
                                   fd.pc_plus4 + {imm[29:0], 2'b00};

    // Drain FSM, sys pulses once after execute and memory are empty
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state <= st_run;
        end else begin
            case (state)
                st_run:   if (fd.valid && is_sys) state <= st_drain;
                st_drain: if (!de.valid && !em.valid) state <= st_sys;
                default:  state <= st_run;
            endcase
        end
    end

    assign sys = (state == st_sys);

    // ------------------------------------------------------------------
    // Decode/execute register
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            de.valid     <= 1'b0;
            de.reg_write <= 1'b0;
            de.mem_read  <= 1'b0;
            de.mem_write <= 1'b0;
        end else begin
            de.valid     <= issue;
            de.reg_write <= issue && reg_write;
            de.mem_read  <= issue && mem_read;
            de.mem_write <= issue && mem_write;
        end
    end

    always_ff @(posedge CLK) begin
        de.alu_op     <= alu_op;
        de.operand_a  <= data_a;
        de.operand_b  <= use_imm ? imm : data_b;
        de.shamt      <= fd.instr[10:6];
        de.dest       <= dest;
        de.store_size <= size;
        de.store_data <= data_b;
    end

endmodule

// File: source/mips_execute.sv
`timescale 1ns/10ps

module mips_execute (
    input  logic      CLK,
    input  logic      RESET,
    id_ex_if.execute  de,
    ex_mem_if.execute em
);
    import mips_pkg::*;

    word_t result;
    logic  slt_bit;

    assign slt_bit = $signed(de.operand_a) < $signed(de.operand_b);

    // ------------------------------------------------------------------
    // ALU and shifter
    // ------------------------------------------------------------------
    always_comb begin
        case (de.alu_op)
            alu_add: result = de.operand_a + de.operand_b;
            alu_sub: result = de.operand_a - de.operand_b;
            alu_and: result = de.operand_a & de.operand_b;
            alu_or:  result = de.operand_a | de.operand_b;
            alu_slt: result = {31'b0, slt_bit};
            // Shift source is rt, carried in operand_b
            alu_sll: result = de.operand_b << de.shamt;
            alu_lui: result = {de.operand_b[15:0], 16'h0000};
            default: result = de.operand_a + de.operand_b;
        endcase
    end

    // ------------------------------------------------------------------
    // Execute/memory register
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else begin
            em.valid     <= de.valid;
            em.reg_write <= de.valid && de.reg_write;
            em.mem_read  <= de.valid && de.mem_read;
            em.mem_write <= de.valid && de.mem_write;
        end
    end

    // Loads and stores carry their address as the result
    always_ff @(posedge CLK) begin
        em.result     <= result;
        em.dest       <= de.dest;
        em.store_size <= de.store_size;
        em.store_data <= de.store_data;
    end

endmodule

// File: source/mips_memory.sv
`timescale 1ns/10ps

module mips_memory (
    input  logic            CLK,
    input  logic            RESET,
    ex_mem_if.memory        em,
    mem_wb_if.memory        wb,
    output mips_pkg::word_t data_addr,
    output mips_pkg::word_t write_data,
    output mips_pkg::size_t write_size,
    output logic            mem_read,
    output logic            mem_write,
    input  mips_pkg::word_t read_data
);
    import mips_pkg::*;

    // ------------------------------------------------------------------
    // Data port
    // ------------------------------------------------------------------
    assign data_addr  = em.result;
    assign mem_read   = em.valid && em.mem_read;
    assign mem_write  = em.valid && em.mem_write;
    assign write_size = em.store_size;

    // Byte store puts the low byte on every lane
    assign write_data = (em.store_size == size_byte) ? {4{em.store_data[7:0]}} :
                                                       em.store_data;

    // ------------------------------------------------------------------
    // Memory/write-back register
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wb.reg_write <= 1'b0;
        end else begin
            wb.reg_write <= em.valid && em.reg_write;
        end
    end

    always_ff @(posedge CLK) begin
        wb.dest <= em.dest;
        wb.data <= em.mem_read ? read_data : em.result;
    end

endmodule

// File: source/mips_core.sv
`timescale 1ns/10ps

module mips_core (
    input  logic             CLK,
    input  logic             RESET,
    output mips_pkg::word_t  instr_addr,
    input  mips_pkg::instr_t instr,
    output mips_pkg::word_t  data_addr,
    output logic             mem_read,
    output logic             mem_write,
    output mips_pkg::word_t  write_data,
    output mips_pkg::size_t  write_size,
    input  mips_pkg::word_t  read_data,
    output logic             sys
);

    // ------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------
    if_id_if  fd_link ();
    id_ex_if  de_link ();
    ex_mem_if em_link ();
    mem_wb_if wb_link ();

    mips_fetch u_fetch (
        .CLK        (CLK),
        .RESET      (RESET),
        .instr_addr (instr_addr),
        .instr      (instr),
        .fd         (fd_link.fetch)
    );

    // Register file lives inside decode
    mips_decode u_decode (
        .CLK   (CLK),
        .RESET (RESET),
        .fd    (fd_link.decode),
        .de    (de_link.decode),
        .em    (em_link.monitor),
        .wb    (wb_link.regfile),
        .sys   (sys)
    );

    mips_execute u_execute (
        .CLK   (CLK),
        .RESET (RESET),
        .de    (de_link.execute),
        .em    (em_link.execute)
    );

    mips_memory u_memory (
        .CLK        (CLK),
        .RESET      (RESET),
        .em         (em_link.memory),
        .wb         (wb_link.memory),
        .data_addr  (data_addr),
        .write_data (write_data),
        .write_size (write_size),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .read_data  (read_data)
    );

endmodule

// File: tests/mips_assert.sv
`timescale 1ns/10ps

module mips_assert (
    input logic            CLK,
    input logic            RESET,
    input logic            mem_read,
    input logic            mem_write,
    input mips_pkg::size_t write_size,
    input logic            sys
);
    import mips_pkg::*;

    // Number of failed assertions
    int failures = 0;

    // Data port does one access at a time
    a_read_write_exclusive: assert property (@(posedge CLK) disable iff (!RESET)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high in the same cycle");
            failures++;
        end

    // Only word and byte stores exist
    a_store_size: assert property (@(posedge CLK) disable iff (!RESET)
        mem_write |-> (write_size == size_word || write_size == size_byte))
        else begin
            $error("write_size out of range during a store");
            failures++;
        end

    a_sys_single: assert property (@(posedge CLK) disable iff (!RESET)
        sys |=> !sys)
        else begin
            $error("sys high for more than one cycle");
            failures++;
        end

    // Strobes quiet while held in reset
    a_reset_quiet: assert property (@(posedge CLK)
        !RESET |-> !(mem_read || mem_write || sys))
        else begin
            $error("strobe high while RESET is low");
            failures++;
        end

endmodule

bind mips_core mips_assert u_assert (
    .CLK        (CLK),
    .RESET      (RESET),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .write_size (write_size),
    .sys        (sys)
);

// File: tests/tb_mips.sv
`timescale 1ns/10ps

module tb_mips;
    import mips_pkg::*;

    logic   CLK;
    logic   RESET;
    word_t  instr_addr;
    instr_t instr;
    word_t  data_addr;
    logic   mem_read;
    logic   mem_write;
    word_t  write_data;
    size_t  write_size;
    word_t  read_data;
    logic   sys;

    instr_t imem [256];
    word_t  dmem [256];
    int     sys_pulses;

    mips_core dut_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .write_data (write_data),
        .write_size (write_size),
        .read_data  (read_data),
        .sys        (sys)
    );

    always #5 CLK = ~CLK;

    // ------------------------------------------------------------------
    // Memory models with combinational read
    // ------------------------------------------------------------------
    assign instr     = imem[instr_addr[9:2]];
    assign read_data = dmem[data_addr[9:2]];

    always @(posedge CLK) begin
        if (RESET && mem_write) begin
            if (write_size == size_byte) begin
                dmem[data_addr[9:2]][8*data_addr[1:0] +: 8] <= write_data[7:0];
            end else begin
                dmem[data_addr[9:2]] <= write_data;
            end
        end
        if (RESET && sys) begin
            sys_pulses = sys_pulses + 1;
        end
    end

    // ------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------
    function automatic instr_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                        input reg_addr_t rd, input shamt_t sh,
                                        input logic [5:0] fn);
        return {op_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t i_format(input logic [5:0] op, input reg_addr_t rs,
                                        input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instr_t j_format(input logic [25:0] index);
        return {op_j, index};
    endfunction

    // LUI then ADDIU with its sign-extended immediate
    function automatic word_t built_value(input logic [15:0] hi, input logic [15:0] lo);
        return {hi, 16'h0000} + {{16{lo[15]}}, lo};
    endfunction

    // ------------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic compare_word(input string what, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("error: %0t ns: %s is %h, expected %h", $time, what, act, exp);
            abort_run();
        end
    endtask

    task automatic compare_size(input string what, input size_t act, input size_t exp);
        if (act !== exp) begin
            $display("error: %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
            abort_run();
        end
    endtask

    // Bound checker failures end the run
    always @(negedge CLK) begin
        if (dut_i.u_assert.failures != 0) begin
            failure("an assertion on the core's memory port or sys failed");
        end
    end

    // ------------------------------------------------------------------
    // Program loading and reset
    // ------------------------------------------------------------------
    task automatic begin_reset();
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        @(negedge CLK);
        RESET      = 1'b0;
        sys_pulses = 0;
    endtask

    task automatic place(input int idx, input instr_t word);
        imem[idx] = word;
    endtask

    // Jump to itself with a NOP in the delay slot
    task automatic add_halt(input int idx);
        place(idx, j_format(26'(idx)));
        place(idx + 1, '0);
    endtask

    task automatic check_reset_outputs();
        if (mem_read !== 1'b0 || mem_write !== 1'b0 || sys !== 1'b0) begin
            failure("a memory strobe or sys is not low during reset");
        end
        compare_word("instr_addr in reset", instr_addr, reset_pc);
    endtask

    task automatic release_reset();
        repeat (16) begin
            @(negedge CLK);
            check_reset_outputs();
        end
        RESET = 1'b1;
        #1;
        check_reset_outputs();
    endtask

    // ------------------------------------------------------------------
    // Waits and absence checks
    // ------------------------------------------------------------------
    task automatic wait_store(input word_t exp_addr, input word_t exp_data,
                              input size_t exp_size, input int exp_pulses);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (!mem_write && cycles < 200) begin
            @(negedge CLK);
            cycles++;
        end
        if (!mem_write) begin
            failure($sformatf("timeout while waiting for the store to %h", exp_addr));
        end
        if (sys_pulses != exp_pulses) begin
            failure($sformatf("store to %h came after %0d sys pulses instead of %0d",
                              exp_addr, sys_pulses, exp_pulses));
        end
        compare_word("store address", data_addr, exp_addr);
        compare_word("store data", write_data, exp_data);
        compare_size("store size", write_size, exp_size);
    endtask

    task automatic wait_sys_pulse();
        int cycles;
        cycles = 0;
        while (sys_pulses == 0 && cycles < 200) begin
            @(negedge CLK);
            if (mem_write) begin
                failure("a store appeared while the syscall was draining");
            end
            cycles++;
        end
        if (sys_pulses != 1) begin
            failure("sys did not pulse exactly once after the syscall");
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            if (mem_write) begin
                failure($sformatf("unexpected store to %h", data_addr));
            end
            if (sys) begin
                failure("unexpected sys pulse");
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_state();
        begin_reset();
        add_halt(0);
        release_reset();
        check_quiet(20);
    endtask

    task automatic test_alu_ops();
        logic [15:0] ahi, alo, bhi, blo;
        shamt_t      sh;
        word_t       a, b;
        word_t       res [6];
        ahi = 16'($urandom);
        alo = 16'($urandom);
        bhi = 16'($urandom);
        blo = 16'($urandom);
        sh  = 5'($urandom_range(1, 31));
        a   = built_value(ahi, alo);
        b   = built_value(bhi, blo);
        // Dependent chain as the program computes it
        res[0] = a + b;
        res[1] = res[0] - a;
        res[2] = res[1] & res[0];
        res[3] = res[2] | a;
        res[4] = ($signed(res[3]) < $signed(b)) ? 32'd1 : 32'd0;
        res[5] = res[3] << sh;
        begin_reset();
        place(0, i_format(op_lui, 5'd0, 5'd1, ahi));
        place(1, i_format(op_addiu, 5'd1, 5'd1, alo));
        place(2, i_format(op_lui, 5'd0, 5'd2, bhi));
        place(3, i_format(op_addiu, 5'd2, 5'd2, blo));
        place(4, r_format(5'd1, 5'd2, 5'd3, 5'd0, fn_addu));
        place(5, r_format(5'd3, 5'd1, 5'd4, 5'd0, fn_subu));
        place(6, r_format(5'd4, 5'd3, 5'd5, 5'd0, fn_and));
        place(7, r_format(5'd5, 5'd1, 5'd6, 5'd0, fn_or));
        place(8, r_format(5'd6, 5'd2, 5'd7, 5'd0, fn_slt));
        place(9, r_format(5'd0, 5'd6, 5'd8, sh, fn_sll));
        for (int i = 0; i < 6; i++) begin
            place(10 + i, i_format(op_sw, 5'd0, 5'(3 + i), 16'(16'h0100 + 4 * i)));
        end
        add_halt(16);
        release_reset();
        for (int i = 0; i < 6; i++) begin
            wait_store(32'h0100 + 4 * i, res[i], size_word, 0);
        end
        check_quiet(20);
    endtask

    task automatic test_load_use();
        word_t w;
        w = $urandom;
        begin_reset();
        dmem[32'h0200 >> 2] = w;
        place(0, i_format(op_lw, 5'd0, 5'd1, 16'h0200));
        place(1, r_format(5'd1, 5'd1, 5'd2, 5'd0, fn_addu));
        place(2, i_format(op_sw, 5'd0, 5'd2, 16'h0204));
        add_halt(3);
        release_reset();
        wait_store(32'h0204, w + w, size_word, 0);
        check_quiet(20);
    endtask

    // Taken BEQ, not-taken BNE and J with storing delay slots
    task automatic test_branches();
        begin_reset();
        place(0, i_format(op_addiu, 5'd0, 5'd1, 16'd5));
        place(1, i_format(op_addiu, 5'd0, 5'd2, 16'd5));
        place(2, i_format(op_beq, 5'd1, 5'd2, 16'd3));
        place(3, i_format(op_sw, 5'd0, 5'd1, 16'h0300));
        place(4, i_format(op_sw, 5'd0, 5'd2, 16'h0304));
        place(5, i_format(op_sw, 5'd0, 5'd2, 16'h0308));
        place(6, i_format(op_bne, 5'd1, 5'd2, 16'd2));
        place(7, i_format(op_addiu, 5'd0, 5'd3, 16'd7));
        place(8, i_format(op_sw, 5'd0, 5'd3, 16'h030c));
        place(9, j_format(26'd12));
        place(10, i_format(op_sw, 5'd0, 5'd1, 16'h0310));
        place(11, i_format(op_sw, 5'd0, 5'd1, 16'h0314));
        place(12, i_format(op_sw, 5'd0, 5'd3, 16'h0318));
        add_halt(13);
        release_reset();
        wait_store(32'h0300, 32'd5, size_word, 0);
        wait_store(32'h030c, 32'd7, size_word, 0);
        wait_store(32'h0310, 32'd5, size_word, 0);
        wait_store(32'h0318, 32'd7, size_word, 0);
        check_quiet(30);
    endtask

    task automatic test_byte_store();
        logic [15:0] hi, lo;
        logic [1:0]  lane;
        word_t       v;
        hi   = 16'($urandom);
        lo   = 16'($urandom);
        lane = 2'($urandom_range(0, 3));
        v    = built_value(hi, lo);
        begin_reset();
        place(0, i_format(op_lui, 5'd0, 5'd1, hi));
        place(1, i_format(op_addiu, 5'd1, 5'd1, lo));
        place(2, i_format(op_sb, 5'd0, 5'd1, {14'h0100, lane}));
        add_halt(3);
        release_reset();
        wait_store({20'h0, 10'h100, lane}, {4{v[7:0]}}, size_byte, 0);
        check_quiet(20);
    endtask

    task automatic test_syscall();
        logic [14:0] val;
        val = 15'($urandom);
        begin_reset();
        place(0, i_format(op_addiu, 5'd0, 5'd1, {1'b0, val}));
        place(1, i_format(op_sw, 5'd0, 5'd1, 16'h0500));
        place(2, r_format(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall));
        place(3, i_format(op_sw, 5'd0, 5'd1, 16'h0504));
        add_halt(4);
        release_reset();
        wait_store(32'h0500, {17'h0, val}, size_word, 0);
        wait_sys_pulse();
        wait_store(32'h0504, {17'h0, val}, size_word, 1);
        check_quiet(20);
    endtask

    initial begin
        CLK        = 1'b0;
        RESET      = 1'b0;
        sys_pulses = 0;
        void'($urandom(32'h7fc8_805c));
        test_reset_state();
        repeat (3) test_alu_ops();
        test_load_use();
        test_branches();
        test_byte_store();
        test_syscall();
        if (dut_i.u_assert.failures == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            failure("an assertion on the core's memory port or sys failed");
        end
    end

endmodule

// File: verilog.f
source/mips_pkg.sv
source/pipe_if.sv
source/mips_fetch.sv
source/mips_regfile.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_memory.sv
source/mips_core.sv
tests/mips_assert.sv
tests/tb_mips.sv
